//--- hw/fifo_consts.svh
`ifndef FIFO_CONSTS_SVH
`define FIFO_CONSTS_SVH

// word width on the write side
`define FIFO_W_DATA_W 32
// byte width on the read side
`define FIFO_R_DATA_W 8

// depth in read units, as an address width (64 bytes)
`define FIFO_ADDR_W 6
// log2 of write width over read width
`define FIFO_RATIO_LOG2 2

`define FIFO_W_ADDR_W (`FIFO_ADDR_W - `FIFO_RATIO_LOG2)
`define FIFO_R_ADDR_W `FIFO_ADDR_W

`endif

//--- hw/fifo_pkg.sv
`default_nettype none

`include "fifo_consts.svh"

package fifo_pkg;

   // per-side flag state, INIT holds both flags high for one cycle
   typedef enum logic [1:0] {
      ST_NORMAL = 2'd0,
      ST_EMPTY  = 2'd1,
      ST_FULL   = 2'd2,
      ST_INIT   = 2'd3
   } fifo_state_e;

   typedef logic [`FIFO_W_DATA_W-1:0] w_data_t;
   typedef logic [`FIFO_R_DATA_W-1:0] r_data_t;

   // one extra bit so a full count of 64 fits
   typedef logic [`FIFO_ADDR_W:0] level_t;

endpackage

`default_nettype wire

//--- hw/gray_ptr.sv
`default_nettype none

module gray_ptr #(
   parameter int W = 4
) (
   input  wire          clk,
   input  wire          rst_n,
   input  wire          inc,
   output logic [W-1:0] gray,
   output logic [W-1:0] bin
);

   logic [W-1:0] bin_nxt;

   assign bin_nxt = bin + W'(1);

   // gray comes straight from a flop so it can cross domains safely
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bin  <= '0;
         gray <= '0;
      end else if (inc) begin
         bin  <= bin_nxt;
         gray <= bin_nxt ^ (bin_nxt >> 1);
      end
   end

endmodule

`default_nettype wire

//--- hw/ram_t2p_asym.sv
`default_nettype none

`include "fifo_consts.svh"

module ram_t2p_asym (
   input  wire                       w_clk,
   input  wire                       w_en,
   input  wire [`FIFO_W_ADDR_W-1:0]  w_addr,
   input  wire fifo_pkg::w_data_t    w_data,
   input  wire                       r_clk,
   input  wire                       r_en,
   input  wire [`FIFO_R_ADDR_W-1:0]  r_addr,
   output fifo_pkg::r_data_t         r_data
);

   import fifo_pkg::*;

   localparam int LANE_W = `FIFO_RATIO_LOG2;
   localparam int RATIO  = 1 << LANE_W;
   localparam int DEPTH  = 1 << `FIFO_R_ADDR_W;
   localparam int BYTE_W = `FIFO_R_DATA_W;

   // storage is kept in read-width units
   r_data_t mem [DEPTH];

   // one word lands in RATIO consecutive bytes, lsb first
   always_ff @(posedge w_clk) begin
      if (w_en) begin
         for (int i = 0; i < RATIO; i++) begin
            mem[{w_addr, LANE_W'(i)}] <= w_data[i*BYTE_W +: BYTE_W];
         end
      end
   end

   // registered read, data valid the cycle after r_en
   always_ff @(posedge r_clk) begin
      if (r_en) begin
         r_data <= mem[r_addr];
      end
   end

endmodule

`default_nettype wire

//--- hw/fifo_wr_ctrl.sv
`default_nettype none

`include "fifo_consts.svh"

module fifo_wr_ctrl (
   input  wire                       w_clk,
   input  wire                       rst_n,
   input  wire                       w_en,
   input  wire [`FIFO_R_ADDR_W-1:0]  rd_gray,
   output logic                      w_full,
   output logic                      w_empty,
   output fifo_pkg::level_t          w_level,
   output logic                      wr_accept,
   output logic [`FIFO_W_ADDR_W-1:0] wr_addr,
   output logic [`FIFO_W_ADDR_W-1:0] wr_gray
);

   import fifo_pkg::*;

   localparam level_t FIFO_SIZE = level_t'(1 << `FIFO_R_ADDR_W);
   localparam level_t W_INCR    = level_t'(1 << `FIFO_RATIO_LOG2);

   fifo_state_e               state;
   fifo_state_e               state_nxt;
   logic [`FIFO_R_ADDR_W-1:0] rd_gray_meta;
   logic [`FIFO_R_ADDR_W-1:0] rd_gray_sync;
   logic [`FIFO_R_ADDR_W-1:0] rd_bin_sync;
   logic [`FIFO_R_ADDR_W-1:0] wr_bin_n;
   logic [`FIFO_R_ADDR_W-1:0] level_int;
   level_t                    level_ext;

   assign wr_accept = w_en & ~w_full;

   gray_ptr #(
      .W(`FIFO_W_ADDR_W)
   ) wr_ptr_inst (
      .clk  (w_clk),
      .rst_n(rst_n),
      .inc  (wr_accept),
      .gray (wr_gray),
      .bin  (wr_addr)
   );

   // read pointer into the write domain
   always_ff @(posedge w_clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_gray_meta <= '0;
         rd_gray_sync <= '0;
      end else begin
         rd_gray_meta <= rd_gray;
         rd_gray_sync <= rd_gray_meta;
      end
   end

   always_comb begin
      for (int i = 0; i < `FIFO_R_ADDR_W; i++) begin
         rd_bin_sync[i] = ^(rd_gray_sync >> i);
      end
   end

   // word pointer scaled to bytes; stale reads make this err high
   assign wr_bin_n  = {wr_addr, {`FIFO_RATIO_LOG2{1'b0}}};
   assign level_int = wr_bin_n - rd_bin_sync;
   assign level_ext = level_t'(level_int);

   always_ff @(posedge w_clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= ST_INIT;
      end else begin
         state <= state_nxt;
      end
   end

   // full is known low in EMPTY and NORMAL, so w_en is the accept there
   always_comb begin
      state_nxt = state;
      w_full    = 1'b0;
      w_empty   = 1'b0;
      w_level   = level_ext;
      case (state)
         ST_INIT: begin
            w_full    = 1'b1;
            w_empty   = 1'b1;
            state_nxt = ST_EMPTY;
         end
         ST_EMPTY: begin
            w_empty = 1'b1;
            if (w_en) begin
               state_nxt = ST_NORMAL;
            end
         end
         ST_NORMAL: begin
            // less than a word of room left after this write
            if (w_en && (level_ext + W_INCR) > (FIFO_SIZE - W_INCR)) begin
               state_nxt = ST_FULL;
            end else if (!w_en && level_ext == '0) begin
               state_nxt = ST_EMPTY;
            end
         end
         ST_FULL: begin
            w_full  = 1'b1;
            w_level = FIFO_SIZE;
            // zero here means the pointer wrapped, still 64 stored
            if (level_ext != '0 && level_ext <= (FIFO_SIZE - W_INCR)) begin
               state_nxt = ST_NORMAL;
            end
         end
         default: state_nxt = ST_INIT;
      endcase
   end

   // an accepted word always has room for all its bytes
   a_write_has_room: assert property (
      @(posedge w_clk) disable iff (!rst_n)
      wr_accept |-> level_ext <= (FIFO_SIZE - W_INCR)
   );

   // empty flag agrees with the synchronized pointers
   a_empty_level_zero: assert property (
      @(posedge w_clk) disable iff (!rst_n)
      w_empty |-> level_ext == '0
   );

endmodule

`default_nettype wire

//--- hw/fifo_rd_ctrl.sv
`default_nettype none

`include "fifo_consts.svh"

module fifo_rd_ctrl (
   input  wire                       r_clk,
   input  wire                       rst_n,
   input  wire                       r_en,
   input  wire [`FIFO_W_ADDR_W-1:0]  wr_gray,
   output logic                      r_empty,
   output logic                      r_full,
   output fifo_pkg::level_t          r_level,
   output logic                      rd_accept,
   output logic [`FIFO_R_ADDR_W-1:0] rd_addr,
   output logic [`FIFO_R_ADDR_W-1:0] rd_gray
);

   import fifo_pkg::*;

   localparam level_t FIFO_SIZE = level_t'(1 << `FIFO_R_ADDR_W);

   fifo_state_e               state;
   fifo_state_e               state_nxt;
   logic [`FIFO_W_ADDR_W-1:0] wr_gray_meta;
   logic [`FIFO_W_ADDR_W-1:0] wr_gray_sync;
   logic [`FIFO_W_ADDR_W-1:0] wr_bin_sync;
   logic [`FIFO_R_ADDR_W-1:0] wr_bin_n;
   logic [`FIFO_R_ADDR_W-1:0] level_int;
   level_t                    level_ext;

   assign rd_accept = r_en & ~r_empty;

   gray_ptr #(
      .W(`FIFO_R_ADDR_W)
   ) rd_ptr_inst (
      .clk  (r_clk),
      .rst_n(rst_n),
      .inc  (rd_accept),
      .gray (rd_gray),
      .bin  (rd_addr)
   );

   // write pointer into the read domain
   always_ff @(posedge r_clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_gray_meta <= '0;
         wr_gray_sync <= '0;
      end else begin
         wr_gray_meta <= wr_gray;
         wr_gray_sync <= wr_gray_meta;
      end
   end

   always_comb begin
      for (int i = 0; i < `FIFO_W_ADDR_W; i++) begin
         wr_bin_sync[i] = ^(wr_gray_sync >> i);
      end
   end

   // stale writes make this err low, never high
   assign wr_bin_n  = {wr_bin_sync, {`FIFO_RATIO_LOG2{1'b0}}};
   assign level_int = wr_bin_n - rd_addr;
   assign level_ext = level_t'(level_int);

   always_ff @(posedge r_clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= ST_INIT;
      end else begin
         state <= state_nxt;
      end
   end

   // empty is known low in NORMAL and FULL, so r_en is the accept there
   always_comb begin
      state_nxt = state;
      r_full    = 1'b0;
      r_empty   = 1'b0;
      r_level   = level_ext;
      case (state)
         ST_INIT: begin
            r_full    = 1'b1;
            r_empty   = 1'b1;
            state_nxt = ST_EMPTY;
         end
         ST_EMPTY: begin
            r_empty = 1'b1;
            if (level_ext != '0) begin
               state_nxt = ST_NORMAL;
            end
         end
         ST_NORMAL: begin
            // a zero difference here is a wrapped pointer, i.e. 64 bytes
            if (level_ext == '0) begin
               r_level = FIFO_SIZE;
            end
            if (r_en && level_ext == level_t'(1)) begin
               state_nxt = ST_EMPTY;
            end else if (!r_en && level_ext == '0) begin
               state_nxt = ST_FULL;
            end
         end
         ST_FULL: begin
            r_full  = 1'b1;
            r_level = FIFO_SIZE;
            if (r_en) begin
               state_nxt = ST_NORMAL;
            end
         end
         default: state_nxt = ST_INIT;
      endcase
   end

   // full means the pointers sit exactly one wrap apart
   a_full_wrapped: assert property (
      @(posedge r_clk) disable iff (!rst_n)
      r_full |-> level_ext == '0
   );

   // init is only ever reached through reset
   a_no_init_reentry: assert property (
      @(posedge r_clk) disable iff (!rst_n)
      state != ST_INIT |=> state != ST_INIT
   );

endmodule

`default_nettype wire

//--- hw/async_fifo_asym.sv
`default_nettype none

`include "fifo_consts.svh"

module async_fifo_asym (
   input  wire                    rst_n,
   input  wire                    w_clk,
   input  wire                    w_en,
   input  wire fifo_pkg::w_data_t w_data,
   output logic                   w_empty,
   output logic                   w_full,
   output fifo_pkg::level_t       w_level,
   input  wire                    r_clk,
   input  wire                    r_en,
   output fifo_pkg::r_data_t      r_data,
   output logic                   r_empty,
   output logic                   r_full,
   output fifo_pkg::level_t       r_level
);

   // write domain toward memory and read side
   logic                      wr_accept;
   logic [`FIFO_W_ADDR_W-1:0] wr_addr;
   logic [`FIFO_W_ADDR_W-1:0] wr_gray;

   // read domain toward memory and write side
   logic                      rd_accept;
   logic [`FIFO_R_ADDR_W-1:0] rd_addr;
   logic [`FIFO_R_ADDR_W-1:0] rd_gray;

   fifo_wr_ctrl fifo_wr_ctrl_inst (
      .w_clk    (w_clk),
      .rst_n    (rst_n),
      .w_en     (w_en),
      .rd_gray  (rd_gray),
      .w_full   (w_full),
      .w_empty  (w_empty),
      .w_level  (w_level),
      .wr_accept(wr_accept),
      .wr_addr  (wr_addr),
      .wr_gray  (wr_gray)
   );

   fifo_rd_ctrl fifo_rd_ctrl_inst (
      .r_clk    (r_clk),
      .rst_n    (rst_n),
      .r_en     (r_en),
      .wr_gray  (wr_gray),
      .r_empty  (r_empty),
      .r_full   (r_full),
      .r_level  (r_level),
      .rd_accept(rd_accept),
      .rd_addr  (rd_addr),
      .rd_gray  (rd_gray)
   );

   // word in, byte out
   ram_t2p_asym ram_t2p_asym_inst (
      .w_clk (w_clk),
      .w_en  (wr_accept),
      .w_addr(wr_addr),
      .w_data(w_data),
      .r_clk (r_clk),
      .r_en  (rd_accept),
      .r_addr(rd_addr),
      .r_data(r_data)
   );

endmodule

`default_nettype wire

//--- verif/tb_async_fifo.sv
`default_nettype none

`include "fifo_consts.svh"

module tb_async_fifo;

   timeunit 1ns;
   timeprecision 1ps;

   import fifo_pkg::*;

   localparam int     BYTE_W        = `FIFO_R_DATA_W;
   localparam int     RATIO         = `FIFO_W_DATA_W / `FIFO_R_DATA_W;
   localparam level_t FULL_LEVEL    = level_t'(1 << `FIFO_ADDR_W);
   localparam int     FLAG_TIMEOUT  = 100;
   localparam int     BURST_SLACK   = 100;
   localparam int     ALL           = -1;
   localparam int     NUM_ROWS      = 10;
   localparam w_data_t BLOCKED_WORD = 32'hB10C_4ED0;

   typedef enum logic [1:0] {OP_WR, OP_RD, OP_MIX} op_e;
   typedef enum logic [1:0] {CHK_NONE, CHK_W_FULL, CHK_R_FULL, CHK_R_EMPTY} chk_e;

   typedef struct packed {
      op_e  op;
      int   count;
      chk_e chk;
      logic exp;
   } row_t;

   // op, count (words, bytes or cycles), flag to wait for, its value
   localparam row_t STIM_TAB [NUM_ROWS] = '{
      '{OP_WR,  4,   CHK_NONE,    1'b0},
      '{OP_RD,  16,  CHK_R_EMPTY, 1'b1},
      '{OP_WR,  16,  CHK_W_FULL,  1'b1},
      '{OP_RD,  0,   CHK_R_FULL,  1'b1},
      '{OP_RD,  64,  CHK_R_EMPTY, 1'b1},
      '{OP_RD,  0,   CHK_W_FULL,  1'b0},
      '{OP_MIX, 300, CHK_NONE,    1'b0},
      '{OP_RD,  ALL, CHK_R_EMPTY, 1'b1},
      '{OP_WR,  2,   CHK_R_EMPTY, 1'b0},
      '{OP_RD,  ALL, CHK_R_EMPTY, 1'b1}
   };

   localparam w_data_t WORD_TAB [8] = '{
      32'h0302_0100, 32'h0706_0504, 32'hA5C3_5A3C, 32'h8000_0001,
      32'h00FF_FF00, 32'h1234_5678, 32'hFEDC_BA98, 32'h0F1E_2D3C
   };

   logic    rst_n;
   logic    w_clk = 1'b0;
   logic    r_clk = 1'b0;
   logic    w_en;
   w_data_t w_data;
   logic    w_empty;
   logic    w_full;
   level_t  w_level;
   logic    r_en;
   r_data_t r_data;
   logic    r_empty;
   logic    r_full;
   level_t  r_level;

   // byte-wide reference queue, lsb of each word first
   r_data_t model_q[$];
   r_data_t rd_expect;
   r_data_t rd_last;
   logic    rd_pending;
   int      word_idx;

   always #20 r_clk = ~r_clk;
   always #29 w_clk = ~w_clk;

   async_fifo_asym async_fifo_asym_inst (
      .rst_n  (rst_n),
      .w_clk  (w_clk),
      .w_en   (w_en),
      .w_data (w_data),
      .w_empty(w_empty),
      .w_full (w_full),
      .w_level(w_level),
      .r_clk  (r_clk),
      .r_en   (r_en),
      .r_data (r_data),
      .r_empty(r_empty),
      .r_full (r_full),
      .r_level(r_level)
   );

   task automatic fail_run();
      $display("sim failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic fail_plain(input string msg);
      $display("%s", msg);
      fail_run();
   endtask

   task automatic check_byte(input string name, input r_data_t got, input r_data_t exp);
      if (got !== exp) begin
         $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
         fail_run();
      end
   endtask

   // exact compare when lo equals hi
   task automatic check_level(input string name, input level_t got,
                              input level_t lo, input level_t hi);
      if ((^got === 1'bx) || got < lo || got > hi) begin
         $display("Error: %s = 0x%0h, expected 0x%0h to 0x%0h", name, got, lo, hi);
         fail_run();
      end
   endtask

   function automatic w_data_t next_word(input int idx);
      return WORD_TAB[idx % 8] ^ {RATIO{8'(idx)}};
   endfunction

   function automatic logic flag_value(input chk_e which);
      case (which)
         CHK_W_FULL: return w_full;
         CHK_R_FULL: return r_full;
         CHK_R_EMPTY: return r_empty;
         default: return 1'b0;
      endcase
   endfunction

   function automatic string flag_name(input chk_e which);
      case (which)
         CHK_W_FULL: return "w_full";
         CHK_R_FULL: return "r_full";
         CHK_R_EMPTY: return "r_empty";
         default: return "none";
      endcase
   endfunction

   // level is checked before this cycle's word enters the model
   task automatic write_cycle(input logic en, input w_data_t data, output logic accepted);
      @(negedge w_clk);
      w_en   = en;
      w_data = data;
      check_level("w_level", w_level, level_t'(model_q.size()), FULL_LEVEL);
      accepted = en && !w_full;
      if (accepted) begin
         for (int i = 0; i < RATIO; i++) begin
            model_q.push_back(data[i*BYTE_W +: BYTE_W]);
         end
      end
   endtask

   task automatic read_cycle(input logic en);
      @(negedge r_clk);
      // byte from the previous accepted read sits on r_data now
      if (rd_pending) begin
         check_byte("r_data", r_data, rd_expect);
         rd_last    = rd_expect;
         rd_pending = 1'b0;
      end
      r_en = en;
      check_level("r_level", r_level, '0, level_t'(model_q.size()));
      if (en && !r_empty) begin
         if (model_q.size() == 0) begin
            fail_plain("read accepted while the model holds no bytes");
         end
         rd_expect  = model_q.pop_front();
         rd_pending = 1'b1;
      end
   endtask

   // dropped strobes are retried with the same word
   task automatic write_burst(input int n);
      int   done;
      int   tries;
      logic acc;
      done  = 0;
      tries = 0;
      while (done < n) begin
         if (tries > n + BURST_SLACK) begin
            fail_plain("write burst did not complete in time");
         end
         write_cycle(1'b1, next_word(word_idx), acc);
         if (acc) begin
            done++;
            word_idx++;
         end
         tries++;
      end
      write_cycle(1'b0, '0, acc);
   endtask

   task automatic read_burst(input int n);
      int done;
      int tries;
      done  = 0;
      tries = 0;
      while (done < n) begin
         if (tries > n + BURST_SLACK) begin
            fail_plain("read burst did not complete in time");
         end
         read_cycle(1'b1);
         if (rd_pending) begin
            done++;
         end
         tries++;
      end
      read_cycle(1'b0);
   endtask

   task automatic random_traffic(input int n);
      logic acc;
      fork
         begin
            for (int i = 0; i < n; i++) begin
               write_cycle(1'($urandom % 2), w_data_t'($urandom), acc);
            end
            write_cycle(1'b0, '0, acc);
         end
         begin
            // reads a little more often than writes
            for (int j = 0; j < n; j++) begin
               read_cycle(1'(($urandom % 4) != 0));
            end
            read_cycle(1'b0);
         end
      join
   endtask

   task automatic wait_flag(input chk_e which, input logic exp);
      int   n;
      logic seen;
      n    = 0;
      seen = 1'b0;
      while (!seen && n < FLAG_TIMEOUT) begin
         if (which == CHK_W_FULL) begin
            @(negedge w_clk);
         end else begin
            @(negedge r_clk);
         end
         seen = (flag_value(which) === exp);
         n++;
      end
      if (!seen) begin
         fail_plain($sformatf("timed out waiting for %s to become %0d", flag_name(which), exp));
      end
   endtask

   task automatic check_after_row(input chk_e which, input logic exp);
      logic acc;
      wait_flag(which, exp);
      case (which)
         CHK_W_FULL: begin
            if (exp) begin
               check_level("w_level", w_level, FULL_LEVEL, FULL_LEVEL);
               // one more word, must be dropped
               write_cycle(1'b1, BLOCKED_WORD, acc);
               write_cycle(1'b0, '0, acc);
               check_flag("w_full", w_full, 1'b1);
            end
         end
         CHK_R_FULL: begin
            if (exp) begin
               check_level("r_level", r_level, FULL_LEVEL, FULL_LEVEL);
            end
         end
         CHK_R_EMPTY: begin
            if (exp) begin
               check_level("r_level", r_level, '0, '0);
               repeat (4) read_cycle(1'b1);
               read_cycle(1'b0);
               // no new read may have happened
               check_byte("r_data", r_data, rd_last);
               if (model_q.size() != 0) begin
                  fail_plain("r_empty is high while the model still holds bytes");
               end
            end
         end
         default: ;
      endcase
   endtask

   task automatic apply_row(input row_t row);
      int n;
      case (row.op)
         OP_WR: write_burst(row.count);
         OP_RD: begin
            n = (row.count == ALL) ? model_q.size() : row.count;
            read_burst(n);
         end
         OP_MIX: random_traffic(row.count);
         default: ;
      endcase
      if (row.chk != CHK_NONE) begin
         check_after_row(row.chk, row.exp);
      end
   endtask

   // full may show only while a side is still in init
   task automatic reset_checks();
      fork
         for (int i = 0; i < 3; i++) begin
            @(negedge w_clk);
            check_flag("w_empty", w_empty, 1'b1);
            check_level("w_level", w_level, '0, '0);
            if (i > 0) begin
               check_flag("w_full", w_full, 1'b0);
            end
         end
         for (int k = 0; k < 3; k++) begin
            @(negedge r_clk);
            check_flag("r_empty", r_empty, 1'b1);
            check_level("r_level", r_level, '0, '0);
            if (k > 0) begin
               check_flag("r_full", r_full, 1'b0);
            end
         end
      join
   endtask

   initial begin
      void'($urandom(77));
      rst_n      = 1'b0;
      w_en       = 1'b0;
      w_data     = '0;
      r_en       = 1'b0;
      rd_expect  = '0;
      rd_last    = '0;
      rd_pending = 1'b0;
      word_idx   = 0;
      repeat (4) @(negedge r_clk);
      rst_n = 1'b1;
      reset_checks();
      for (int i = 0; i < NUM_ROWS; i++) begin
         apply_row(STIM_TAB[i]);
      end
      $display("sim passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- all.f
+incdir+hw
hw/fifo_pkg.sv
hw/gray_ptr.sv
hw/ram_t2p_asym.sv
hw/fifo_wr_ctrl.sv
hw/fifo_rd_ctrl.sv
hw/async_fifo_asym.sv
verif/tb_async_fifo.sv

//--- run_sim.sh
#!/bin/sh
# build and run the asymmetric async FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_async_fifo -Mdir "$OBJ" -f all.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./"$OBJ"/Vtb_async_fifo > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

# the log decides the result
if grep -q "^sim passed$" "$LOG"; then
   exit 0
fi
echo "pass line not found in $LOG"
exit 1
